// File: filelist.f
logic/pa_stream_pkg.sv
logic/pa_prefix_pkg.sv
logic/prefix_ib_parser.sv
logic/prefix_table_lane.sv
logic/prefix_inserter.sv
logic/prefix_attach_top.sv
testbench/tb_clock.sv
testbench/prefix_attach_sva.sv
testbench/prefix_attach_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module prefix_attach_tb \
  -f filelist.f \
  -o prefix_attach_sim \
  && ./obj_dir/prefix_attach_sim \
  && echo "simulation finished with exit status 0" \
  || { echo "build or simulation failed" >&2; exit 1; }

// File: testbench/prefix_attach_tb.sv
// testbench top for the prefix attacher that pushes random frames through a FIFO model into a queue-model checker
`default_nettype none

module prefix_attach_tb;

  import pa_stream_pkg::*;
  import pa_prefix_pkg::*;

  localparam int BLOCK_WORDS   = 4;
  localparam int NUM_FRAMES    = 40;
  localparam int RUN_TIMEOUT   = 20000;
  localparam int DRAIN_TIMEOUT = 400;

  logic         clk;
  logic         rst_n;
  logic         in_empty;
  logic         in_rd;
  stream_word_t in_word;
  logic         out_afull;
  logic         out_valid;
  stream_word_t out_word;

  logic [31:0]  lfsr;
  logic [31:0]  gap_bits;
  logic [31:0]  afull_bits;
  stream_word_t src_q[$];  // words still held by the source FIFO model
  stream_word_t exp_q[$];  // output words still to come, in order
  stream_word_t expected_word;
  int           expect_total;
  int           words_seen;

  tb_clock #(.PERIOD(100), .RESET_CYCLES(4)) u_clock (.clk(clk), .rst_n(rst_n));

  prefix_attach_top #(.BLOCK_WORDS(BLOCK_WORDS)) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_empty  (in_empty),
    .in_rd     (in_rd),
    .in_word   (in_word),
    .out_afull (out_afull),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input logic [$bits(stream_word_t)-1:0] got,
                             input logic [$bits(stream_word_t)-1:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;  // taps 32, 22, 2, 1
    end
    return n;
  endfunction

  task automatic random_bits(input int count, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < count; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // table content as defined for lane, prefix number and word index
  function automatic logic [63:0] table_rule(input int lane, input logic [5:0] pnum,
                                             input int idx);
    logic [31:0] low;
    low = (32'(idx) * 32'h01010101) ^ {26'd0, pnum};
    return {16'hA000 + 16'(lane), 10'd0, pnum, low};
  endfunction

  function automatic logic [15:0] half_sum(input logic [63:0] w);
    return w[15:0] + w[31:16] + w[47:32] + w[63:48];
  endfunction

  task automatic expect_block(input int lane, input logic [5:0] pnum);
    stream_word_t w;
    logic [15:0]  sum;
    sum = '0;
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      w.typen = (lane == LANE_PFD) ? PFD_INS : PHD_INS;
      w.sot   = (i == 0);
      w.eot   = 1'b0;
      w.tdata = table_rule(lane, pnum, i);
      sum     = sum + half_sum(w.tdata);
      exp_q.push_back(w);
    end
    w.typen = CHK;
    w.sot   = 1'b0;
    w.eot   = 1'b1;
    w.tdata = (64'(lane) << 16) | 64'(sum);  // lane tag sits just above the checksum
    exp_q.push_back(w);
  endtask

  task automatic build_frame(input int frame);
    stream_word_t w;
    logic [31:0]  r;
    logic [1:0]   mode;
    logic [5:0]   pnum;
    int           n_data;
    random_bits(2, r);
    mode = (frame < 3) ? 2'(frame) : r[1:0];  // the first three frames cover each real mode
    random_bits(6, r);
    pnum = r[5:0];
    random_bits(3, r);
    n_data  = 1 + int'(r[2:0]) % 6;
    w.typen = CMD;
    w.sot   = 1'b1;
    w.eot   = 1'b1;
    w.tdata = {40'd0, 16'(frame), pnum, mode};
    src_q.push_back(w);
    case (prefix_mode_e'(mode))
      PFD_ONLY: expect_block(LANE_PFD, pnum);
      PHD_PFD: begin
        expect_block(LANE_PHD, pnum);
        expect_block(LANE_PFD, pnum);
      end
      default: ;  // reserved mode inserts nothing just like NONE
    endcase
    for (int i = 0; i < n_data; i++) begin
      random_bits(32, r);
      w.typen = DATA;
      w.sot   = (i == 0);
      w.eot   = 1'b0;
      w.tdata = {16'(frame), 16'(i), r};
      src_q.push_back(w);
      exp_q.push_back(w);
    end
    random_bits(32, r);
    w.typen = FTR;
    w.sot   = 1'b0;
    w.eot   = 1'b1;
    w.tdata = {16'(frame), 16'hffff, r};
    src_q.push_back(w);
    exp_q.push_back(w);
  endtask

  // the source FIFO and the back-pressure both change on the falling edge
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      in_empty  = 1'b1;
      in_word   = '0;
      out_afull = 1'b0;
    end else begin
      random_bits(2, gap_bits);
      random_bits(2, afull_bits);
      out_afull = (afull_bits[1:0] == 2'b00);
      if (src_q.size() == 0 || gap_bits[1:0] == 2'b00) begin
        in_empty = 1'b1;
        in_word  = '0;
      end else begin
        in_empty = 1'b0;
        in_word  = src_q[0];
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n === 1'b0) begin
      check_value(($bits(stream_word_t))'(out_valid), '0, "out_valid during reset");
    end else if (rst_n === 1'b1) begin
      check_value(($bits(stream_word_t))'(in_rd & out_afull), '0,
                  "in_rd while out_afull is high");
      if (in_rd) begin
        if (src_q.size() == 0) begin
          $display("the DUT read at time %0t while the FIFO model was empty", $time);
          stop_with_failure();
        end else begin
          src_q.delete(0);
        end
      end
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("an extra output word %h appeared at time %0t", out_word, $time);
          stop_with_failure();
        end else begin
          expected_word = exp_q.pop_front();
          check_value(out_word, expected_word, $sformatf("output word %0d", words_seen));
          words_seen++;
        end
      end
    end
  end

  initial begin
    int cycles;
    lfsr       = 32'hf354;
    in_empty   = 1'b1;
    in_word    = '0;
    out_afull  = 1'b0;
    words_seen = 0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      build_frame(f);
    end
    expect_total = exp_q.size();

    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 10) begin
        $display("reset was not released within 10 cycles");
        stop_with_failure();
      end
    end

    cycles = 0;
    while (src_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > RUN_TIMEOUT) begin
        $display("the DUT stopped reading with %0d words left in the FIFO model", src_q.size());
        stop_with_failure();
      end
    end

    cycles = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        $display("%0d expected output words never came out", exp_q.size());
        stop_with_failure();
      end
    end

    repeat (20) @(negedge clk);  // an idle tail lets a stray extra word still get caught
    if (exp_q.size() == 0 && words_seen == expect_total) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("only %0d of %0d expected words were seen", words_seen, expect_total);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// File: testbench/prefix_attach_sva.sv
// protocol assertions for the prefix inserter that bind attaches to every inserter instance
`default_nettype none

module prefix_attach_sva (
  input wire                                 clk,
  input wire                                 rst_n,
  input wire                                 out_afull,
  input wire                                 out_valid,
  input wire                                 ins_done,
  input wire [pa_prefix_pkg::NUM_LANES-1:0]  insert_req,
  input wire [pa_prefix_pkg::NUM_LANES-1:0]  lane_step
);

  // the parser pipe gives two words of slack and then the output has to stay quiet
  afull_quiets_output: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_afull && $past(out_afull) && $past(out_afull, 2) |-> !out_valid
  ) else $error("out_valid seen after out_afull was high for three cycles");

  ins_done_closes_request: assert property (
    @(posedge clk) disable iff (!rst_n)
    ins_done |=> !ins_done && (insert_req == '0)
  ) else $error("ins_done lasted more than one cycle or the insert request was not dropped");

  single_requested_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(lane_step) && ((lane_step & ~insert_req) == '0)
  ) else $error("a table lane stepped without its request or together with the other lane");

endmodule

bind prefix_inserter prefix_attach_sva u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .out_afull  (out_afull),
  .out_valid  (out_valid),
  .ins_done   (ins_done),
  .insert_req (insert_req),
  .lane_step  (lane_step)
);

`default_nettype wire

// File: testbench/tb_clock.sv
// clock and reset source for the prefix attacher testbench, instantiated once in its top module
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  // reset covers RESET_CYCLES rising edges and is let go on the next falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: logic/prefix_attach_top.sv
// top level of the stream prefix attacher, connects parser, table lanes and inserter
`default_nettype none

module prefix_attach_top #(
  parameter int BLOCK_WORDS = 4
) (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               in_empty,
  output logic                              in_rd,
  input  wire pa_stream_pkg::stream_word_t  in_word,
  input  wire                               out_afull,
  output logic                              out_valid,
  output pa_stream_pkg::stream_word_t       out_word
);

  import pa_stream_pkg::*;
  import pa_prefix_pkg::*;

  logic                                pw_valid;
  stream_word_t                        pw_word;
  logic                                ins_done;
  logic [NUM_LANES-1:0]                lane_ld;
  logic [PREFIX_NUM_W-1:0]             lane_prefix_num;
  logic [NUM_LANES-1:0]                insert_req;
  logic [NUM_LANES-1:0]                lane_step;
  logic [NUM_LANES-1:0]                lane_last;
  logic [NUM_LANES-1:0][WORD_W-1:0]    lane_word;
  logic [NUM_LANES-1:0][CHK_W-1:0]     lane_checksum;

  prefix_ib_parser u_parser (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_empty        (in_empty),
    .in_word         (in_word),
    .out_afull       (out_afull),
    .ins_done        (ins_done),
    .in_rd           (in_rd),
    .pw_valid        (pw_valid),
    .pw_word         (pw_word),
    .lane_ld         (lane_ld),
    .lane_prefix_num (lane_prefix_num),
    .insert_req      (insert_req)
  );

  // lane 0 serves the PHD table, lane 1 the PFD table
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    prefix_table_lane #(
      .LANE        (g),
      .BLOCK_WORDS (BLOCK_WORDS)
    ) u_lane (
      .clk        (clk),
      .rst_n      (rst_n),
      .ld         (lane_ld[g]),
      .prefix_num (lane_prefix_num),
      .step       (lane_step[g]),
      .word       (lane_word[g]),
      .last       (lane_last[g]),
      .checksum   (lane_checksum[g])
    );
  end

  prefix_inserter #(
    .BLOCK_WORDS (BLOCK_WORDS)
  ) u_inserter (
    .clk           (clk),
    .rst_n         (rst_n),
    .pw_valid      (pw_valid),
    .pw_word       (pw_word),
    .insert_req    (insert_req),
    .lane_word     (lane_word),
    .lane_last     (lane_last),
    .lane_checksum (lane_checksum),
    .out_afull     (out_afull),
    .lane_step     (lane_step),
    .ins_done      (ins_done),
    .out_valid     (out_valid),
    .out_word      (out_word)
  );

endmodule

`default_nettype wire

// File: logic/prefix_inserter.sv
// outbound merger, passes parser words or emits the requested prefix blocks with checksums
`default_nettype none

module prefix_inserter #(
  parameter int BLOCK_WORDS = 4
) (
  input  wire                                                         clk,
  input  wire                                                         rst_n,
  input  wire                                                         pw_valid,
  input  wire pa_stream_pkg::stream_word_t                            pw_word,
  input  wire [pa_prefix_pkg::NUM_LANES-1:0]                          insert_req,
  input  wire [pa_prefix_pkg::NUM_LANES-1:0][pa_prefix_pkg::WORD_W-1:0] lane_word,
  input  wire [pa_prefix_pkg::NUM_LANES-1:0]                          lane_last,
  input  wire [pa_prefix_pkg::NUM_LANES-1:0][pa_prefix_pkg::CHK_W-1:0]  lane_checksum,
  input  wire                                                         out_afull,
  output logic [pa_prefix_pkg::NUM_LANES-1:0]                         lane_step,
  output logic                                                        ins_done,
  output logic                                                        out_valid,
  output pa_stream_pkg::stream_word_t                                 out_word
);

  import pa_stream_pkg::*;
  import pa_prefix_pkg::*;

  localparam int LANE_W = $clog2(NUM_LANES);
  localparam int CNT_W  = $clog2(BLOCK_WORDS + 1);

  typedef enum logic [2:0] {
    S_PASS,
    S_PHD,
    S_PHD_CHK,
    S_PFD,
    S_PFD_CHK,
    S_DONE
  } state_e;

  state_e            state;
  state_e            state_nxt;
  logic              drained;
  logic [CNT_W-1:0]  blk_cnt;
  logic              in_pfd;
  logic [LANE_W-1:0] cur_lane;

  assign in_pfd   = (state == S_PFD) | (state == S_PFD_CHK);
  assign cur_lane = in_pfd ? LANE_W'(LANE_PFD) : LANE_W'(LANE_PHD);
  assign ins_done = (state == S_DONE);

  always_comb begin
    state_nxt = state;
    case (state)
      S_PASS: begin
        // the request has been up a full cycle, so the pipe holds no older word
        if ((|insert_req) && drained && !pw_valid) begin
          state_nxt = insert_req[LANE_PHD] ? S_PHD : S_PFD;
        end
      end
      S_PHD: if (!out_afull && lane_last[LANE_PHD]) state_nxt = S_PHD_CHK;
      S_PHD_CHK: if (!out_afull) state_nxt = insert_req[LANE_PFD] ? S_PFD : S_DONE;
      S_PFD: if (!out_afull && lane_last[LANE_PFD]) state_nxt = S_PFD_CHK;
      S_PFD_CHK: if (!out_afull) state_nxt = S_DONE;
      default: state_nxt = S_PASS;
    endcase
  end

  always_comb begin
    out_valid = 1'b0;
    out_word  = pw_word;
    lane_step = '0;
    case (state)
      S_PASS: out_valid = pw_valid;
      S_PHD, S_PFD: begin
        out_valid           = ~out_afull;  // insertion pauses word by word
        lane_step[cur_lane] = ~out_afull;
        out_word.typen      = in_pfd ? PFD_INS : PHD_INS;
        out_word.sot        = (blk_cnt == '0);
        out_word.eot        = 1'b0;
        out_word.tdata      = lane_word[cur_lane];
      end
      S_PHD_CHK, S_PFD_CHK: begin
        out_valid                         = ~out_afull;
        out_word.typen                    = CHK;
        out_word.sot                      = 1'b0;
        out_word.eot                      = 1'b1;
        out_word.tdata                    = '0;
        out_word.tdata[CHK_W-1:0]         = lane_checksum[cur_lane];
        out_word.tdata[CHK_W +: LANE_W]   = cur_lane;  // lane tag above the sum
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= S_PASS;
      drained <= 1'b0;
      blk_cnt <= '0;
    end else begin
      state   <= state_nxt;
      drained <= (state == S_PASS) & (|insert_req);
      if (state_nxt != state) begin
        blk_cnt <= '0;
      end else if (|lane_step) begin
        blk_cnt <= blk_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/prefix_table_lane.sv
// one prefix table lane, walks a block of table words from a loaded prefix and sums them
`default_nettype none

module prefix_table_lane #(
  parameter int LANE        = 0,
  parameter int BLOCK_WORDS = 4
) (
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire                                    ld,
  input  wire [pa_prefix_pkg::PREFIX_NUM_W-1:0]  prefix_num,
  input  wire                                    step,
  output logic [pa_prefix_pkg::WORD_W-1:0]       word,
  output logic                                   last,
  output logic [pa_prefix_pkg::CHK_W-1:0]        checksum
);

  import pa_prefix_pkg::*;

  localparam int IDX_W = $clog2(BLOCK_WORDS + 1);
  localparam int HALVES = WORD_W / CHK_W;

  logic [PREFIX_NUM_W-1:0] base;
  logic [IDX_W-1:0]        idx;
  logic [CHK_W-1:0]        word_sum;

  assign word = table_word(LANE, base, int'(idx));
  assign last = (idx == IDX_W'(BLOCK_WORDS - 1));

  // 16-bit halves of the current word, wrapping modulo 2^16
  always_comb begin
    word_sum = '0;
    for (int h = 0; h < HALVES; h++) begin
      word_sum = word_sum + word[h*CHK_W +: CHK_W];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx      <= '0;
      checksum <= '0;
    end else if (ld) begin
      idx      <= '0;  // restart the walk at the block's first word
      checksum <= '0;
    end else if (step) begin
      idx      <= idx + 1'b1;
      checksum <= checksum + word_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (ld) begin
      base <= prefix_num;
    end
  end

endmodule

`default_nettype wire

// File: logic/prefix_ib_parser.sv
// inbound side of the prefix attacher, reads the upstream FIFO and raises prefix insert requests
`default_nettype none

module prefix_ib_parser (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire                                        in_empty,
  input  wire pa_stream_pkg::stream_word_t           in_word,
  input  wire                                        out_afull,
  input  wire                                        ins_done,
  output logic                                       in_rd,
  output logic                                       pw_valid,
  output pa_stream_pkg::stream_word_t                pw_word,
  output logic [pa_prefix_pkg::NUM_LANES-1:0]        lane_ld,
  output logic [pa_prefix_pkg::PREFIX_NUM_W-1:0]     lane_prefix_num,
  output logic [pa_prefix_pkg::NUM_LANES-1:0]        insert_req
);

  import pa_stream_pkg::*;
  import pa_prefix_pkg::*;

  stream_word_t s0_word;
  logic         s0_valid;
  logic         cmd_last;
  logic         rd_cmd;
  prefix_mode_e mode;
  logic         want_phd;
  logic         want_pfd;
  logic         req_pending;

  // a raised request keeps the frame's first DATA word in the FIFO until the inserter is done
  assign req_pending = |insert_req;

  // out_afull cuts reading at once, the two pipe stages give the slack downstream
  assign in_rd = ~in_empty & ~out_afull & ~req_pending;

  assign rd_cmd   = in_rd & (in_word.typen == CMD);
  assign cmd_last = rd_cmd & in_word.eot;  // the mode is only valid on the closing CMD word
  assign mode     = cmd_mode(in_word.tdata);

  // reserved mode falls through to no insertion
  assign want_phd = cmd_last & (mode == PHD_PFD);
  assign want_pfd = cmd_last & ((mode == PHD_PFD) | (mode == PFD_ONLY));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_ld    <= '0;
      insert_req <= '0;
    end else begin
      lane_ld[LANE_PHD] <= want_phd;  // load strobes last one cycle
      lane_ld[LANE_PFD] <= want_pfd;

      if (ins_done) begin
        insert_req <= '0;
      end else begin
        if (want_phd) begin
          insert_req[LANE_PHD] <= 1'b1;
        end
        if (want_pfd) begin
          insert_req[LANE_PFD] <= 1'b1;
        end
      end
    end
  end

  // prefix number for the lanes, captured with the load strobes
  always_ff @(posedge clk) begin
    if (cmd_last) begin
      lane_prefix_num <= cmd_prefix_num(in_word.tdata);
    end
  end

  // two-stage word pipe, CMD words enter it as bubbles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s0_valid <= 1'b0;
      pw_valid <= 1'b0;
    end else begin
      s0_valid <= in_rd & ~rd_cmd;
      pw_valid <= s0_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_rd) begin
      s0_word <= in_word;
    end
    pw_word <= s0_word;
  end

endmodule

`default_nettype wire

// File: logic/pa_prefix_pkg.sv
// prefix modes, lane numbering, table geometry and the table content rule shared by RTL and testbench
`default_nettype none

package pa_prefix_pkg;

  typedef enum logic [1:0] {
    NONE      = 2'd0,
    PFD_ONLY  = 2'd1,
    PHD_PFD   = 2'd2,
    MODE_RSVD = 2'd3  // treated as NONE
  } prefix_mode_e;

  localparam int LANE_PHD     = 0;
  localparam int LANE_PFD     = 1;
  localparam int NUM_LANES    = 2;
  localparam int PREFIX_NUM_W = 6;
  localparam int WORD_W       = 64;
  localparam int CHK_W        = 16;

  // the CMD eot word holds the mode in tdata[1:0] and the prefix number in tdata[7:2]
  localparam int CMD_MODE_LSB = 0;
  localparam int CMD_PNUM_LSB = 2;

  function automatic prefix_mode_e cmd_mode(input logic [WORD_W-1:0] tdata);
    return prefix_mode_e'(tdata[CMD_MODE_LSB +: 2]);
  endfunction

  function automatic logic [PREFIX_NUM_W-1:0] cmd_prefix_num(input logic [WORD_W-1:0] tdata);
    return tdata[CMD_PNUM_LSB +: PREFIX_NUM_W];
  endfunction

  function automatic logic [WORD_W-1:0] table_word(input int lane,
                                                   input logic [PREFIX_NUM_W-1:0] pnum,
                                                   input int idx);
    logic [15:0] tag;
    logic [31:0] low;
    tag = 16'hA000 + 16'(lane);
    low = (32'(idx) * 32'h01010101) ^ 32'(pnum);
    return {tag, 16'(pnum), low};
  endfunction

endpackage

`default_nettype wire

// File: logic/pa_stream_pkg.sv
// stream word format of the prefix attacher, imported by every block that moves stream words
`default_nettype none

package pa_stream_pkg;

  localparam int DATA_W = 64;
  localparam int TYPE_W = 3;

  // word-type codes carried in typen
  typedef enum logic [TYPE_W-1:0] {
    CMD     = 3'd0,
    DATA    = 3'd1,
    FTR     = 3'd2,
    PHD_INS = 3'd3,  // inserted prefix header block word
    PFD_INS = 3'd4,  // inserted prefix data block word
    CHK     = 3'd5   // closing checksum of an inserted block
  } word_type_e;

  typedef struct packed {
    word_type_e        typen;
    logic              sot;
    logic              eot;
    logic [DATA_W-1:0] tdata;
  } stream_word_t;

endpackage

`default_nettype wire
